/* run_sim.sh */
#!/usr/bin/env bash
# Builds the RV32I core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_rv32_core -o tb_rv32_core_sim
./obj_dir/tb_rv32_core_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Result: passed"
else
    echo "Result: failed"
    exit 1
fi

/* rv32_cases.txt */
// Word 0 program length, word 1 record count, then program words from address 0, four a line
// Then retire records of three words each: pc rd rd_data, the last record is the EBREAK
2E 25
123450B7 FF900113 00300193 00310233   // 00 lui x1 / addi x2 -7 / addi x3 3 / add x4
402182B3 00319333 003123B3 00313433   // 10 sub x5 / sll x6 / slt x7 / sltu x8
0020C4B3 00315533 403155B3 0030E633   // 20 xor x9 / srl x10 / sra x11 / or x12
001176B3 4040D713 FFF74793 00508013   // 30 and x13 / srai x14 / xori x15 / addi x0
00F02423 00802803 003808B3 00500913   // 40 sw x15 / lw x16 / add x17 on load / addi x18 5
00391463 00100993 00390463 00314463   // 50 bne after x18 write / skipped / beq / blt
00200993 0021C463 00316463 0021E463   // 60 skipped / blt / bltu / bltu
00300993 00315463 0021D463 00400993   // 70 skipped / bge / bge / skipped
0021F463 00317463 00500993 01290463   // 80 bgeu / bgeu / skipped / beq
00600993 00319463 00C00A6F 00700993   // 90 skipped / bne / jal x20 +12 / skipped
00800993 0B100A93 000A8B67 00900993   // A0 skipped / addi x21 0xB1 / jalr x22 / skipped
014B0BB3 00100073                     // B0 add x23 / ebreak
00000000 01 12345000   00000004 02 FFFFFFF9
00000008 03 00000003   0000000C 04 FFFFFFFC
00000010 05 0000000A   00000014 06 00000018
00000018 07 00000001   0000001C 08 00000000
00000020 09 EDCBAFF9   00000024 0A 1FFFFFFF
00000028 0B FFFFFFFF   0000002C 0C 12345003
00000030 0D 12345000   00000034 0E 01234500
00000038 0F FEDCBAFF   0000003C 00 00000000
00000040 00 00000000   00000044 10 FEDCBAFF
00000048 11 FEDCBB02   0000004C 12 00000005
00000050 00 00000000   00000058 00 00000000
0000005C 00 00000000   00000064 00 00000000
00000068 00 00000000   0000006C 00 00000000
00000074 00 00000000   00000078 00 00000000
00000080 00 00000000   00000084 00 00000000
0000008C 00 00000000   00000094 00 00000000
00000098 14 0000009C   000000A4 15 000000B1
000000A8 16 000000AC   000000B0 17 00000148
000000B4 00 00000000

/* rv32_core.sv */
/*
 * Top level of the four-stage RV32I core
 * Fetch, decode, execute, memory/writeback and register file
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
    input  wire                          i_clk,
    input  wire                          i_rst,
    output logic [rv32_pkg::XLEN-1:0]    o_imem_addr,
    input  wire [rv32_pkg::XLEN-1:0]     i_imem_data,
    output logic [rv32_pkg::XLEN-1:0]    o_dmem_addr,
    output logic                         o_dmem_ren,
    output logic                         o_dmem_wen,
    output logic [rv32_pkg::XLEN-1:0]    o_dmem_wdata,
    input  wire [rv32_pkg::XLEN-1:0]     i_dmem_rdata,
    output logic                         o_retire_valid,
    output logic                         o_retire_halt,
    output logic [rv32_pkg::XLEN-1:0]    o_retire_pc,
    output logic [rv32_pkg::REG_AW-1:0]  o_retire_rd,
    output logic [rv32_pkg::XLEN-1:0]    o_retire_rd_data
);
    import rv32_pkg::*;

    // ==============================
    // Stage-to-stage signals
    // ==============================
    logic              stall, redirect, f_valid, ex_wen, wb_wen;
    logic [XLEN-1:0]   redirect_pc, f_inst, f_pc, rs1_data, rs2_data, wb_data;
    logic [REG_AW-1:0] rs1_addr, rs2_addr, ex_rd, wb_rd;
    // D/E
    logic              x_valid, x_is_link, x_use_imm, x_wen, x_load, x_store, x_halt;
    alu_op_e           x_alu_op;
    logic [XLEN-1:0]   x_op1, x_op2, x_store_data, x_link, x_pc;
    logic [REG_AW-1:0] x_rs1, x_rs2, x_rd;
    // E/M
    logic              m_valid, m_wen, m_load, m_store, m_halt;
    logic [XLEN-1:0]   m_result, m_store_data, m_pc;
    logic [REG_AW-1:0] m_rd;

    rv32_fetch u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_stall(stall),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc), .i_imem_data(i_imem_data),
        .o_imem_addr(o_imem_addr), .o_inst(f_inst), .o_pc(f_pc), .o_valid(f_valid)
    );

    rv32_regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_rd_addr(wb_rd), .i_rd_wen(wb_wen), .i_rd_data(wb_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv32_decode u_decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_inst(f_inst), .i_pc(f_pc), .i_valid(f_valid),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_ex_rd(ex_rd), .i_ex_wen(ex_wen),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_stall(stall),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_x_valid(x_valid), .o_x_alu_op(x_alu_op), .o_x_op1(x_op1), .o_x_op2(x_op2),
        .o_x_store_data(x_store_data), .o_x_link(x_link), .o_x_is_link(x_is_link),
        .o_x_use_imm(x_use_imm), .o_x_rs1(x_rs1), .o_x_rs2(x_rs2), .o_x_rd(x_rd),
        .o_x_wen(x_wen), .o_x_load(x_load), .o_x_store(x_store), .o_x_halt(x_halt),
        .o_x_pc(x_pc)
    );

    rv32_execute u_execute (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(x_valid), .i_alu_op(x_alu_op),
        .i_op1(x_op1), .i_op2(x_op2), .i_store_data(x_store_data), .i_link(x_link),
        .i_is_link(x_is_link), .i_use_imm(x_use_imm), .i_rs1(x_rs1), .i_rs2(x_rs2),
        .i_rd(x_rd), .i_wen(x_wen), .i_load(x_load), .i_store(x_store), .i_halt(x_halt),
        .i_pc(x_pc), .i_wb_rd(wb_rd), .i_wb_wen(wb_wen), .i_wb_data(wb_data),
        .o_ex_rd(ex_rd), .o_ex_wen(ex_wen), .o_m_valid(m_valid), .o_m_result(m_result),
        .o_m_store_data(m_store_data), .o_m_rd(m_rd), .o_m_wen(m_wen),
        .o_m_load(m_load), .o_m_store(m_store), .o_m_halt(m_halt), .o_m_pc(m_pc)
    );

    rv32_mem_wb u_mem_wb (
        .i_valid(m_valid), .i_result(m_result), .i_store_data(m_store_data),
        .i_rd(m_rd), .i_wen(m_wen), .i_load(m_load), .i_store(m_store),
        .i_halt(m_halt), .i_pc(m_pc), .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
        .o_wb_rd(wb_rd), .o_wb_wen(wb_wen), .o_wb_data(wb_data),
        .o_retire_valid(o_retire_valid), .o_retire_halt(o_retire_halt),
        .o_retire_pc(o_retire_pc), .o_retire_rd(o_retire_rd),
        .o_retire_rd_data(o_retire_rd_data)
    );

endmodule

`default_nettype wire

/* rv32_decode.sv */
/*
 * Decode stage
 * Field and control decode, immediates, branch compare,
 * next-PC selection, hazard stall and the decode/execute register
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_decode (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire [rv32_pkg::XLEN-1:0]     i_inst,
    input  wire [rv32_pkg::XLEN-1:0]     i_pc,
    input  wire                          i_valid,
    input  wire [rv32_pkg::XLEN-1:0]     i_rs1_data,     // Register file data with bypass
    input  wire [rv32_pkg::XLEN-1:0]     i_rs2_data,
    input  wire [rv32_pkg::REG_AW-1:0]   i_ex_rd,        // Destination now in execute
    input  wire                          i_ex_wen,
    output logic [rv32_pkg::REG_AW-1:0]  o_rs1_addr,
    output logic [rv32_pkg::REG_AW-1:0]  o_rs2_addr,
    output logic                         o_stall,
    output logic                         o_redirect,
    output logic [rv32_pkg::XLEN-1:0]    o_redirect_pc,
    output logic                         o_x_valid,
    output rv32_pkg::alu_op_e            o_x_alu_op,
    output logic [rv32_pkg::XLEN-1:0]    o_x_op1,
    output logic [rv32_pkg::XLEN-1:0]    o_x_op2,
    output logic [rv32_pkg::XLEN-1:0]    o_x_store_data,
    output logic [rv32_pkg::XLEN-1:0]    o_x_link,
    output logic                         o_x_is_link,
    output logic                         o_x_use_imm,
    output logic [rv32_pkg::REG_AW-1:0]  o_x_rs1,
    output logic [rv32_pkg::REG_AW-1:0]  o_x_rs2,
    output logic [rv32_pkg::REG_AW-1:0]  o_x_rd,
    output logic                         o_x_wen,
    output logic                         o_x_load,
    output logic                         o_x_store,
    output logic                         o_x_halt,
    output logic [rv32_pkg::XLEN-1:0]    o_x_pc
);
    import rv32_pkg::*;

    inst_u           ins;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    logic            is_op, is_imm, is_lui, is_load, is_store, is_br, is_jal, is_jalr, is_sys;
    logic            alt, wen, use_imm, br_eq, br_lt, br_ltu, br_taken, bubble;
    alu_op_e         alu_op;

    assign ins        = i_inst;
    assign o_rs1_addr = ins.r.rs1;
    assign o_rs2_addr = ins.r.rs2;

    // ==============================
    // Immediates
    // ==============================
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};   // Store view
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // ==============================
    // Control decode
    // ==============================
    assign is_op    = (ins.r.opcode == OPC_OP);
    assign is_imm   = (ins.r.opcode == OPC_OP_IMM);
    assign is_lui   = (ins.r.opcode == OPC_LUI);
    assign is_load  = (ins.r.opcode == OPC_LOAD);
    assign is_store = (ins.r.opcode == OPC_STORE);
    assign is_br    = (ins.r.opcode == OPC_BRANCH);
    assign is_jal   = (ins.r.opcode == OPC_JAL);
    assign is_jalr  = (ins.r.opcode == OPC_JALR);
    assign is_sys   = (ins.r.opcode == OPC_SYSTEM);   // EBREAK halts

    // funct7[5] picks SUB only for OP, SRA for both ALU groups
    assign alt     = ins.r.funct7[5] && (is_op || ins.r.funct3 == 3'b101);
    assign wen     = is_op || is_imm || is_lui || is_load || is_jal || is_jalr;
    assign use_imm = is_imm || is_lui || is_load || is_store;
    assign imm     = is_lui ? imm_u : (is_store ? imm_s : imm_i);

    always_comb begin
        case (ins.r.funct3)
            3'b000:  alu_op = alt ? SUB : ADD;
            3'b001:  alu_op = SLL;
            3'b010:  alu_op = SLT;
            3'b011:  alu_op = SLTU;
            3'b100:  alu_op = XOR;
            3'b101:  alu_op = alt ? SRA : SRL;
            3'b110:  alu_op = OR;
            default: alu_op = AND;
        endcase
        if (is_lui) alu_op = PASS_B;
        else if (!(is_op || is_imm)) alu_op = ADD;      // Address add for LW/SW
    end

    // ==============================
    // Branch resolution and stall
    // ==============================
    assign br_eq  = (i_rs1_data == i_rs2_data);
    assign br_lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
    assign br_ltu = (i_rs1_data < i_rs2_data);

    always_comb begin
        case (ins.r.funct3)
            3'b000:  br_taken = br_eq;        // BEQ
            3'b001:  br_taken = !br_eq;       // BNE
            3'b100:  br_taken = br_lt;        // BLT
            3'b101:  br_taken = !br_lt;       // BGE
            3'b110:  br_taken = br_ltu;       // BLTU
            3'b111:  br_taken = !br_ltu;      // BGEU
            default: br_taken = 1'b0;
        endcase
    end

    // Wait a cycle for the register file bypass when an operand is still in execute
    assign o_stall = i_valid && (is_br || is_jalr) && i_ex_wen && (i_ex_rd != '0)
                     && ((i_ex_rd == ins.r.rs1) || (is_br && i_ex_rd == ins.r.rs2));

    assign o_redirect    = i_valid && !o_stall && (is_jal || is_jalr || (is_br && br_taken));
    assign o_redirect_pc = is_jalr ? ((i_rs1_data + imm_i) & ~XLEN'(1))
                                   : (i_pc + (is_jal ? imm_j : imm_b));
    assign bubble        = o_stall || !i_valid;

    // ==============================
    // D/E register
    // ==============================
    always_ff @(posedge i_clk) begin
        o_x_alu_op     <= alu_op;
        o_x_op1        <= i_rs1_data;
        o_x_op2        <= use_imm ? imm : i_rs2_data;
        o_x_store_data <= i_rs2_data;
        o_x_link       <= i_pc + XLEN'(4);            // Return address for JAL/JALR
        o_x_use_imm    <= use_imm;
        o_x_rs1        <= ins.r.rs1;
        o_x_rs2        <= ins.r.rs2;
        o_x_rd         <= ins.r.rd;
        o_x_pc         <= i_pc;
        if (i_rst || bubble) begin
            o_x_valid   <= 1'b0;
            o_x_is_link <= 1'b0;
            o_x_wen     <= 1'b0;
            o_x_load    <= 1'b0;
            o_x_store   <= 1'b0;
            o_x_halt    <= 1'b0;
        end else begin
            o_x_valid   <= 1'b1;
            o_x_is_link <= is_jal || is_jalr;
            o_x_wen     <= wen;
            o_x_load    <= is_load;
            o_x_store   <= is_store;
            o_x_halt    <= is_sys;
        end
    end

    // A stall lasts one cycle since the bubble leaves execute with no pending write
    ap_stall_one_cycle : assert property (@(posedge i_clk) disable iff (i_rst)
        o_stall |=> !o_stall)
        else $error("decode stalled two cycles in a row");

endmodule

`default_nettype wire

/* rv32_execute.sv */
/*
 * Execute stage
 * Operand forwarding from memory/writeback, ALU,
 * link-value selection and the execute/memory register
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_execute (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_valid,
    input  rv32_pkg::alu_op_e            i_alu_op,
    input  wire [rv32_pkg::XLEN-1:0]     i_op1,
    input  wire [rv32_pkg::XLEN-1:0]     i_op2,          // Immediate or rs2 data
    input  wire [rv32_pkg::XLEN-1:0]     i_store_data,
    input  wire [rv32_pkg::XLEN-1:0]     i_link,
    input  wire                          i_is_link,
    input  wire                          i_use_imm,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rs1,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rs2,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rd,
    input  wire                          i_wen,
    input  wire                          i_load,
    input  wire                          i_store,
    input  wire                          i_halt,
    input  wire [rv32_pkg::XLEN-1:0]     i_pc,
    input  wire [rv32_pkg::REG_AW-1:0]   i_wb_rd,
    input  wire                          i_wb_wen,
    input  wire [rv32_pkg::XLEN-1:0]     i_wb_data,
    output logic [rv32_pkg::REG_AW-1:0]  o_ex_rd,        // To decode hazard check
    output logic                         o_ex_wen,
    output logic                         o_m_valid,
    output logic [rv32_pkg::XLEN-1:0]    o_m_result,
    output logic [rv32_pkg::XLEN-1:0]    o_m_store_data,
    output logic [rv32_pkg::REG_AW-1:0]  o_m_rd,
    output logic                         o_m_wen,
    output logic                         o_m_load,
    output logic                         o_m_store,
    output logic                         o_m_halt,
    output logic [rv32_pkg::XLEN-1:0]    o_m_pc
);
    import rv32_pkg::*;

    logic            fwd_a, fwd_b;
    logic [XLEN-1:0] a, b, st_data, alu_res;

    assign o_ex_rd  = i_rd;
    assign o_ex_wen = i_valid && i_wen;

    // ==============================
    // Forwarding
    // ==============================
    assign fwd_a   = i_wb_wen && (i_wb_rd != '0) && (i_wb_rd == i_rs1);
    assign fwd_b   = i_wb_wen && (i_wb_rd != '0) && (i_wb_rd == i_rs2);
    assign a       = fwd_a ? i_wb_data : i_op1;
    assign b       = (fwd_b && !i_use_imm) ? i_wb_data : i_op2;   // Immediate is never replaced
    assign st_data = fwd_b ? i_wb_data : i_store_data;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (i_alu_op)
            ADD:     alu_res = a + b;
            SUB:     alu_res = a - b;
            SLL:     alu_res = a << b[4:0];
            SLT:     alu_res = XLEN'($signed(a) < $signed(b));
            SLTU:    alu_res = XLEN'(a < b);
            XOR:     alu_res = a ^ b;
            SRL:     alu_res = a >> b[4:0];
            SRA:     alu_res = $unsigned($signed(a) >>> b[4:0]);
            OR:      alu_res = a | b;
            AND:     alu_res = a & b;
            default: alu_res = b;              // PASS_B
        endcase
    end

    // E/M register
    always_ff @(posedge i_clk) begin
        o_m_result     <= i_is_link ? i_link : alu_res;   // JAL/JALR write PC+4
        o_m_store_data <= st_data;
        o_m_rd         <= i_rd;
        o_m_pc         <= i_pc;
        if (i_rst) begin
            o_m_valid <= 1'b0;
            o_m_wen   <= 1'b0;
            o_m_load  <= 1'b0;
            o_m_store <= 1'b0;
            o_m_halt  <= 1'b0;
        end else begin
            o_m_valid <= i_valid;
            o_m_wen   <= i_valid && i_wen;
            o_m_load  <= i_valid && i_load;
            o_m_store <= i_valid && i_store;
            o_m_halt  <= i_valid && i_halt;
        end
    end

endmodule

`default_nettype wire

/* rv32_fetch.sv */
/*
 * Fetch stage
 * Program counter and fetch/decode register,
 * with stall hold and redirect flush
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_fetch (
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire                        i_stall,        // Hold PC and F/D register
    input  wire                        i_redirect,     // Jump or taken branch in decode
    input  wire [rv32_pkg::XLEN-1:0]   i_redirect_pc,
    input  wire [rv32_pkg::XLEN-1:0]   i_imem_data,    // Combinational read data
    output logic [rv32_pkg::XLEN-1:0]  o_imem_addr,
    output logic [rv32_pkg::XLEN-1:0]  o_inst,
    output logic [rv32_pkg::XLEN-1:0]  o_pc,
    output logic                       o_valid
);
    import rv32_pkg::*;

    logic [XLEN-1:0] pc;

    assign o_imem_addr = pc;   // Memory answers in the same cycle

    // ==============================
    // PC and F/D register
    // ==============================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc      <= RESET_ADDR;
            o_inst  <= NOP_INST;
            o_valid <= 1'b0;
        end else if (i_redirect) begin
            pc      <= i_redirect_pc;
            o_inst  <= NOP_INST;           // Wrong-path word becomes a bubble
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            pc      <= pc + XLEN'(4);
            o_inst  <= i_imem_data;
            o_pc    <= pc;
            o_valid <= 1'b1;
        end
        // Stalled: everything holds
    end

    // Redirect targets from decode keep the PC on word boundaries
    ap_pc_aligned : assert property (@(posedge i_clk) disable iff (i_rst)
        o_imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned: %h", o_imem_addr);

endmodule

`default_nettype wire

/* rv32_mem_wb.sv */
/*
 * Memory/writeback stage, combinational
 * Data-memory drive, writeback select, retire report
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_wb (
    input  wire                          i_valid,
    input  wire [rv32_pkg::XLEN-1:0]     i_result,       // ALU result, address or link
    input  wire [rv32_pkg::XLEN-1:0]     i_store_data,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rd,
    input  wire                          i_wen,
    input  wire                          i_load,
    input  wire                          i_store,
    input  wire                          i_halt,
    input  wire [rv32_pkg::XLEN-1:0]     i_pc,
    input  wire [rv32_pkg::XLEN-1:0]     i_dmem_rdata,
    output logic [rv32_pkg::XLEN-1:0]    o_dmem_addr,
    output logic [rv32_pkg::XLEN-1:0]    o_dmem_wdata,
    output logic                         o_dmem_ren,
    output logic                         o_dmem_wen,
    output logic [rv32_pkg::REG_AW-1:0]  o_wb_rd,
    output logic                         o_wb_wen,
    output logic [rv32_pkg::XLEN-1:0]    o_wb_data,
    output logic                         o_retire_valid,
    output logic                         o_retire_halt,
    output logic [rv32_pkg::XLEN-1:0]    o_retire_pc,
    output logic [rv32_pkg::REG_AW-1:0]  o_retire_rd,
    output logic [rv32_pkg::XLEN-1:0]    o_retire_rd_data
);
    import rv32_pkg::*;

    logic rd_written;

    // Data memory, word accesses only
    assign o_dmem_addr  = i_result;
    assign o_dmem_wdata = i_store_data;
    assign o_dmem_ren   = i_valid && i_load;
    assign o_dmem_wen   = i_valid && i_store;   // Lands at the next edge

    // Writeback, load data arrives in this same cycle
    assign o_wb_rd    = i_rd;
    assign o_wb_wen   = i_valid && i_wen;
    assign o_wb_data  = i_load ? i_dmem_rdata : i_result;
    assign rd_written = o_wb_wen && (i_rd != '0);

    // ==============================
    // Retire report
    // ==============================
    assign o_retire_valid   = i_valid;
    assign o_retire_halt    = i_valid && i_halt;
    assign o_retire_pc      = i_pc;
    assign o_retire_rd      = rd_written ? i_rd : '0;       // x0 and no-write both show 0
    assign o_retire_rd_data = rd_written ? o_wb_data : XLEN'(0);

    // Address comes from execute, only aligned words are supported
    always_comb begin
        if (o_dmem_ren || o_dmem_wen) begin
            assert (o_dmem_addr[1:0] == 2'b00)
                else $error("data access not word aligned: %h", o_dmem_addr);
        end
    end

endmodule

`default_nettype wire

/* rv32_pkg.sv */
/*
 * Shared definitions for the four-stage RV32I core
 * Widths, reset address, NOP encoding, opcodes,
 * ALU operation codes and the instruction-word union
 */
`default_nettype none

package rv32_pkg;

    // ==============================
    // Widths and constants
    // ==============================
    localparam int XLEN   = 32;                          // Data and address width
    localparam int REG_AW = 5;                           // Register address width

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_INST   = 32'h0000_0013;   // addi x0,x0,0

    // ==============================
    // Major opcodes
    // ==============================
    localparam logic [6:0] OPC_OP     = 7'b0110011;      // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;      // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;      // Only EBREAK is acted on

    // ALU operation, set in decode and run in execute
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B                                           // LUI, operand b straight through
    } alu_op_e;

    // ==============================
    // Instruction word views
    // ==============================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;                              // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                              // imm[4:0] where R has rd
        logic [6:0] opcode;
    } inst_s_t;

    // Same 32 bits, register fields or store immediate
    typedef union packed {
        inst_r_t r;
        inst_s_t s;
    } inst_u;

endpackage

`default_nettype wire

/* rv32_regfile.sv */
/*
 * Register file, 32 x 32
 * Two read ports, one write port, x0 reads zero,
 * write data bypassed to a read of the same register
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_regfile (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rs1_addr,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rs2_addr,
    input  wire [rv32_pkg::REG_AW-1:0]   i_rd_addr,
    input  wire                          i_rd_wen,
    input  wire [rv32_pkg::XLEN-1:0]     i_rd_data,
    output logic [rv32_pkg::XLEN-1:0]    o_rs1_data,
    output logic [rv32_pkg::XLEN-1:0]    o_rs2_data
);
    import rv32_pkg::*;

    logic [XLEN-1:0] regs [1:2**REG_AW-1];   // No storage for x0
    logic            wr_ok;

    assign wr_ok = i_rd_wen && !i_rst && (i_rd_addr != '0);

    always_ff @(posedge i_clk) begin
        if (wr_ok) regs[i_rd_addr] <= i_rd_data;
    end

    // Read with bypass, so decode sees a result written this cycle
    always_comb begin
        if (i_rs1_addr == '0)                          o_rs1_data = '0;
        else if (wr_ok && (i_rd_addr == i_rs1_addr))   o_rs1_data = i_rd_data;
        else                                           o_rs1_data = regs[i_rs1_addr];

        if (i_rs2_addr == '0)                          o_rs2_data = '0;
        else if (wr_ok && (i_rd_addr == i_rs2_addr))   o_rs2_data = i_rd_data;
        else                                           o_rs2_data = regs[i_rs2_addr];
    end

endmodule

`default_nettype wire

/* src.f */
rv32_pkg.sv
rv32_fetch.sv
rv32_regfile.sv
rv32_decode.sv
rv32_execute.sv
rv32_mem_wb.sv
rv32_core.sv
tb_rv32_core.sv

/* tb_rv32_core.sv */
/*
 * Testbench for the four-stage RV32I core
 * Clock and reset, instruction and data memory models,
 * retire checker driven by rv32_cases.txt, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int CLK_HALF    = 2;                  // 4 ns period
    localparam int RST_CYC     = 5;
    localparam int CASE_WORDS  = 512;                // Room for program plus records
    localparam int MEM_WORDS   = 256;                // 1 KB for each memory
    localparam int CYC_PER_REC = 20;                 // Watchdog budget per retire

    logic              clk, rst, loaded;
    logic [XLEN-1:0]   imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    logic              dmem_ren, dmem_wen;
    logic              retire_valid, retire_halt;
    logic [XLEN-1:0]   retire_pc, retire_rd_data;
    logic [REG_AW-1:0] retire_rd;

    logic [XLEN-1:0]   case_words [0:CASE_WORDS-1]; // Raw case file
    logic [XLEN-1:0]   imem [0:MEM_WORDS-1];
    logic [XLEN-1:0]   dmem [0:MEM_WORDS-1];
    int                prog_len, num_rec, rec_idx;

    rv32_core rv32_core_i (
        .i_clk(clk), .i_rst(rst),
        .o_imem_addr(imem_addr), .i_imem_data(imem_data),
        .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
        .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata),
        .o_retire_valid(retire_valid), .o_retire_halt(retire_halt),
        .o_retire_pc(retire_pc), .o_retire_rd(retire_rd),
        .o_retire_rd_data(retire_rd_data)
    );

    // ==============================
    // Memory models
    // ==============================
    // Past the end of the program fetch sees NOPs
    assign imem_data  = ((imem_addr >> 2) < XLEN'(prog_len)) ? imem[imem_addr[9:2]] : NOP_INST;

    // Read data only while the core raises its read enable
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[9:2]] : 32'hBAD0_0BAD;

    always @(posedge clk) begin
        if (dmem_wen) dmem[dmem_addr[9:2]] = dmem_wdata;    // Write lands at the edge
    end

    // ==============================
    // Run control
    // ==============================
    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped: %s", why);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run("DUT output differs from expected value");
        end
    endtask

    // Case file holds length, record count, program words and pc/rd/data triples
    task automatic load_cases();
        int i;
        $readmemh("rv32_cases.txt", case_words);
        prog_len = int'(case_words[0]);
        num_rec  = int'(case_words[1]);
        if (prog_len == 0 || num_rec == 0 || prog_len > MEM_WORDS
            || 2 + prog_len + 3 * num_rec > CASE_WORDS) begin
            abort_run("case file is missing, empty or too large");
        end else begin
            for (i = 0; i < prog_len; i++) imem[i] = case_words[2 + i];
            for (i = 0; i < MEM_WORDS; i++) dmem[i] = 32'hDA7A_0000 ^ XLEN'(i * 4);
        end
    endtask

    // Compare one retire with the next record and expect halt only on the last one
    task automatic compare_retire();
        int   base;
        logic last;
        base = 2 + prog_len + 3 * rec_idx;
        last = (rec_idx == num_rec - 1);
        check_value("o_retire_pc", retire_pc, case_words[base]);
        check_value("o_retire_rd", XLEN'(retire_rd), case_words[base + 1]);
        check_value("o_retire_rd_data", retire_rd_data, case_words[base + 2]);
        check_value("o_retire_halt", XLEN'(retire_halt), XLEN'(last));
        rec_idx++;
        if (retire_halt) begin
            $display("Simulation finished: PASS");
            $finish;
        end
    endtask

    // ==============================
    // Clock, reset and checker
    // ==============================
    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        rst     = 1'b1;
        loaded  = 1'b0;
        rec_idx = 0;
        load_cases();
        loaded = 1'b1;
        repeat (RST_CYC) @(posedge clk);
        #1 rst = 1'b0;                               // Released just after the edge
    end

    // Sample mid-cycle when outputs have settled from the last edge
    always @(negedge clk) begin
        if (rst) begin
            check_value("o_retire_valid", XLEN'(retire_valid), XLEN'(0));
            check_value("o_retire_halt", XLEN'(retire_halt), XLEN'(0));
            check_value("o_dmem_ren", XLEN'(dmem_ren), XLEN'(0));
            check_value("o_dmem_wen", XLEN'(dmem_wen), XLEN'(0));
        end else if (retire_valid) begin
            compare_retire();
        end
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (RST_CYC + CYC_PER_REC * num_rec) @(posedge clk);
        abort_run("timeout, EBREAK never retired");
    end

endmodule

`default_nettype wire
